//--- logic/calc_isa_pkg.sv
// ####################
// Integer instruction encodings
// R-type and I-type views of one instruction word
// ####################

package calc_isa_pkg;

  localparam int INSTR_W    = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes that are executed
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
  // Turns add into sub in register form
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } rtype_s;

  // Immediate overlays funct7 and rs2
  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } itype_s;

  typedef union packed {
    rtype_s rtype;
    itype_s itype;
  } instr_u;

endpackage

//--- logic/calc_pipe_pkg.sv
// ####################
// Execute pipeline geometry
// Widths, stage indices, tap count
// ####################

package calc_pipe_pkg;

  localparam int DATA_W = 32;

  // Stage 0 is loaded at dispatch, the last stage is writeback
  localparam int COMP_STAGES = 4;

  // Stage each pipe result is merged into
  localparam int INT_STAGE = 1;
  localparam int MUL_STAGE = 3;

  // Multiplier registers, one fewer than its completion stage
  localparam int MUL_REGS = MUL_STAGE - 1;

  // Next state of stages 1 to 3, plus the writeback register
  localparam int FWD_SRCS = 4;

endpackage

//--- logic/calc_issue.sv
// ####################
// Issue stage
// Decode, operand bypass, reservation register
// ####################

`timescale 1ns/100ps

module calc_issue
(
    input  logic                                                  clk_i
  , input  logic                                                  arst_n_i
  , input  logic                                                  dispatch_v_i
  , input  logic                                                  dispatch_poison_i
  , input  calc_isa_pkg::instr_u                                  dispatch_instr_i
  , input  logic [calc_pipe_pkg::DATA_W-1:0]                      dispatch_rs1_i
  , input  logic [calc_pipe_pkg::DATA_W-1:0]                      dispatch_rs2_i
  , input  logic [calc_pipe_pkg::FWD_SRCS-1:0]                    fwd_v_i
  , input  logic [calc_pipe_pkg::FWD_SRCS-1:0][calc_isa_pkg::REG_ADDR_W-1:0] fwd_addr_i
  , input  logic [calc_pipe_pkg::FWD_SRCS-1:0][calc_pipe_pkg::DATA_W-1:0]    fwd_data_i
  , output calc_isa_pkg::instr_u                                  res_instr_o
  , output logic [calc_pipe_pkg::DATA_W-1:0]                      res_rs1_o
  , output logic [calc_pipe_pkg::DATA_W-1:0]                      res_rs2_o
  , output logic                                                  res_int_v_o
  , output logic                                                  res_mul_v_o
  , output logic                                                  stage0_w_v_o
  , output logic [calc_isa_pkg::REG_ADDR_W-1:0]                   stage0_rd_o
);

  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;

  logic              is_op;
  logic              is_op_imm;
  logic              f3_known;
  logic              op_f7_ok;
  logic              is_int;
  logic              is_mul;
  logic [DATA_W-1:0] rs1_fwd;
  logic [DATA_W-1:0] rs2_fwd;

  // Lowest tap index wins, x0 never bypasses
  function automatic logic [DATA_W-1:0] bypass
  (
      input logic [REG_ADDR_W-1:0] addr
    , input logic [DATA_W-1:0]     rf_data
  );
    logic [DATA_W-1:0] val;
    val = rf_data;
    for (int i = FWD_SRCS-1; i >= 0; i--)
    begin
      if (fwd_v_i[i] && (fwd_addr_i[i] == addr) && (addr != '0))
        val = fwd_data_i[i];
    end
    return val;
  endfunction

  assign is_op     = (dispatch_instr_i.rtype.opcode == OPC_OP);
  assign is_op_imm = (dispatch_instr_i.itype.opcode == OPC_OP_IMM);

  always_comb
  begin
    case (dispatch_instr_i.rtype.funct3)
      F3_ADD, F3_SLL, F3_SLT, F3_XOR, F3_SRL, F3_OR, F3_AND: f3_known = 1'b1;
      default: f3_known = 1'b0;
    endcase
  end

  // Alternate funct7 only legal as sub
  assign op_f7_ok = (dispatch_instr_i.rtype.funct7 == '0)
                  || ((dispatch_instr_i.rtype.funct7 == FUNCT7_ALT)
                      && (dispatch_instr_i.rtype.funct3 == F3_ADD));

  assign is_mul = dispatch_v_i && is_op
                  && (dispatch_instr_i.rtype.funct7 == FUNCT7_MULDIV)
                  && (dispatch_instr_i.rtype.funct3 == F3_ADD);
  assign is_int = dispatch_v_i && f3_known && ((is_op && op_f7_ok) || is_op_imm);

  // Stage 0 entry of the completion pipe
  assign stage0_w_v_o = (is_int || is_mul) && !dispatch_poison_i
                        && (dispatch_instr_i.rtype.rd != '0);
  assign stage0_rd_o  = dispatch_instr_i.rtype.rd;

  always_comb
  begin
    rs1_fwd = bypass(dispatch_instr_i.rtype.rs1, dispatch_rs1_i);
    rs2_fwd = bypass(dispatch_instr_i.rtype.rs2, dispatch_rs2_i);
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      res_int_v_o <= 1'b0;
      res_mul_v_o <= 1'b0;
    end
    else
    begin
      res_int_v_o <= is_int;
      res_mul_v_o <= is_mul;
    end
  end

  always_ff @(posedge clk_i)
  begin
    res_instr_o <= dispatch_instr_i;
    res_rs1_o   <= rs1_fwd;
    res_rs2_o   <= rs2_fwd;
  end

endmodule

//--- logic/calc_pipe_int.sv
// ####################
// Integer ALU pipe, one cycle
// ####################

`timescale 1ns/100ps

module calc_pipe_int
(
    input  calc_isa_pkg::instr_u             res_instr_i
  , input  logic [calc_pipe_pkg::DATA_W-1:0] res_rs1_i
  , input  logic [calc_pipe_pkg::DATA_W-1:0] res_rs2_i
  , input  logic                             res_int_v_i
  , output logic [calc_pipe_pkg::DATA_W-1:0] int_data_o
  , output logic                             int_v_o
);

  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;

  logic              reg_form;
  logic [DATA_W-1:0] imm_ext;
  logic [DATA_W-1:0] opb;
  logic [4:0]        shamt;

  assign reg_form = (res_instr_i.rtype.opcode == OPC_OP);
  assign imm_ext  = DATA_W'($signed(res_instr_i.itype.imm));
  assign opb      = reg_form ? res_rs2_i : imm_ext;
  assign shamt    = opb[4:0];

  always_comb
  begin
    case (res_instr_i.rtype.funct3)
      F3_ADD:
      begin
        if (reg_form && (res_instr_i.rtype.funct7 == FUNCT7_ALT))
          int_data_o = res_rs1_i - opb;
        else
          int_data_o = res_rs1_i + opb;
      end
      F3_SLL:  int_data_o = res_rs1_i << shamt;
      F3_SLT:  int_data_o = DATA_W'($signed(res_rs1_i) < $signed(opb));
      F3_XOR:  int_data_o = res_rs1_i ^ opb;
      F3_SRL:  int_data_o = res_rs1_i >> shamt;
      F3_OR:   int_data_o = res_rs1_i | opb;
      F3_AND:  int_data_o = res_rs1_i & opb;
      default: int_data_o = '0;
    endcase
  end

  assign int_v_o = res_int_v_i;

endmodule

//--- logic/calc_pipe_mul.sv
// ####################
// Pipelined multiplier
// Low half of the product
// ####################

`timescale 1ns/100ps

module calc_pipe_mul
(
    input  logic                             clk_i
  , input  logic                             arst_n_i
  , input  logic [calc_pipe_pkg::DATA_W-1:0] res_rs1_i
  , input  logic [calc_pipe_pkg::DATA_W-1:0] res_rs2_i
  , input  logic                             res_mul_v_i
  , output logic [calc_pipe_pkg::DATA_W-1:0] mul_data_o
  , output logic                             mul_v_o
);

  import calc_pipe_pkg::*;

  logic [MUL_REGS-1:0]             v_r;
  logic [MUL_REGS-1:0][DATA_W-1:0] prod_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      v_r <= '0;
    else
      v_r <= {v_r[MUL_REGS-2:0], res_mul_v_i};
  end

  // Multiply lands in the first register, later ones only carry it
  always_ff @(posedge clk_i)
  begin
    prod_r[0] <= res_rs1_i * res_rs2_i;
    for (int i = 1; i < MUL_REGS; i++)
      prod_r[i] <= prod_r[i-1];
  end

  assign mul_data_o = prod_r[MUL_REGS-1];
  assign mul_v_o    = v_r[MUL_REGS-1];

endmodule

//--- logic/calc_completion.sv
// ####################
// Completion pipeline
// Flush masking, forwarding taps, writeback
// ####################

`timescale 1ns/100ps

module calc_completion
(
    input  logic                                                  clk_i
  , input  logic                                                  arst_n_i
  , input  logic                                                  flush_i
  , input  logic                                                  stage0_w_v_i
  , input  logic [calc_isa_pkg::REG_ADDR_W-1:0]                   stage0_rd_i
  , input  logic [calc_pipe_pkg::DATA_W-1:0]                      int_data_i
  , input  logic                                                  int_v_i
  , input  logic [calc_pipe_pkg::DATA_W-1:0]                      mul_data_i
  , input  logic                                                  mul_v_i
  , output logic [calc_pipe_pkg::FWD_SRCS-1:0]                    fwd_v_o
  , output logic [calc_pipe_pkg::FWD_SRCS-1:0][calc_isa_pkg::REG_ADDR_W-1:0] fwd_addr_o
  , output logic [calc_pipe_pkg::FWD_SRCS-1:0][calc_pipe_pkg::DATA_W-1:0]    fwd_data_o
  , output logic                                                  iwb_v_o
  , output logic [calc_isa_pkg::REG_ADDR_W-1:0]                   iwb_addr_o
  , output logic [calc_pipe_pkg::DATA_W-1:0]                      iwb_data_o
);

  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;

  logic [COMP_STAGES-1:0]                 w_v_n;
  logic [COMP_STAGES-1:0]                 w_v_r;
  logic [COMP_STAGES-1:0][REG_ADDR_W-1:0] rd_n;
  logic [COMP_STAGES-1:0][REG_ADDR_W-1:0] rd_r;
  logic [COMP_STAGES-1:0][DATA_W-1:0]     data_n;
  logic [COMP_STAGES-1:0][DATA_W-1:0]     data_r;

  always_comb
  begin
    w_v_n[0]  = stage0_w_v_i;
    rd_n[0]   = stage0_rd_i;
    data_n[0] = '0;
    for (int i = 1; i < COMP_STAGES; i++)
    begin
      w_v_n[i]  = w_v_r[i-1];
      rd_n[i]   = rd_r[i-1];
      data_n[i] = data_r[i-1];
    end
    // Static latencies, so at most one pipe finishes per stage
    if (int_v_i)
      data_n[INT_STAGE] |= int_data_i;
    if (mul_v_i)
      data_n[MUL_STAGE] |= mul_data_i;
    // Everything not yet entering writeback is cancelled
    for (int i = 0; i < COMP_STAGES-1; i++)
      w_v_n[i] &= ~flush_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      w_v_r <= '0;
    else
      w_v_r <= w_v_n;
  end

  always_ff @(posedge clk_i)
  begin
    rd_r   <= rd_n;
    data_r <= data_n;
  end

  always_comb
  begin
    for (int i = 0; i < FWD_SRCS-1; i++)
    begin
      fwd_v_o[i]    = w_v_n[i+1];
      fwd_addr_o[i] = rd_n[i+1];
      fwd_data_o[i] = data_n[i+1];
    end
    // Last tap is the writeback register itself
    fwd_v_o[FWD_SRCS-1]    = w_v_r[COMP_STAGES-1];
    fwd_addr_o[FWD_SRCS-1] = rd_r[COMP_STAGES-1];
    fwd_data_o[FWD_SRCS-1] = data_r[COMP_STAGES-1];
  end

  assign iwb_v_o    = w_v_r[COMP_STAGES-1];
  assign iwb_addr_o = rd_r[COMP_STAGES-1];
  assign iwb_data_o = data_r[COMP_STAGES-1];

endmodule

//--- logic/calc_top.sv
// ####################
// Execute stage top level
// Issue, ALU and multiply pipes, completion
// ####################

`timescale 1ns/100ps

module calc_top
(
    input  logic                                clk_i
  , input  logic                                arst_n_i
  , input  logic                                dispatch_v_i
  , input  logic                                dispatch_poison_i
  , input  calc_isa_pkg::instr_u                dispatch_instr_i
  , input  logic [calc_pipe_pkg::DATA_W-1:0]    dispatch_rs1_i
  , input  logic [calc_pipe_pkg::DATA_W-1:0]    dispatch_rs2_i
  , input  logic                                flush_i
  , output logic                                iwb_v_o
  , output logic [calc_isa_pkg::REG_ADDR_W-1:0] iwb_addr_o
  , output logic [calc_pipe_pkg::DATA_W-1:0]    iwb_data_o
);

  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;

  instr_u                              res_instr;
  logic [DATA_W-1:0]                   res_rs1;
  logic [DATA_W-1:0]                   res_rs2;
  logic                                res_int_v;
  logic                                res_mul_v;
  logic                                stage0_w_v;
  logic [REG_ADDR_W-1:0]               stage0_rd;
  logic [DATA_W-1:0]                   int_data;
  logic                                int_v;
  logic [DATA_W-1:0]                   mul_data;
  logic                                mul_v;
  logic [FWD_SRCS-1:0]                 fwd_v;
  logic [FWD_SRCS-1:0][REG_ADDR_W-1:0] fwd_addr;
  logic [FWD_SRCS-1:0][DATA_W-1:0]     fwd_data;

  calc_issue u_issue
  (
      .clk_i(clk_i), .arst_n_i(arst_n_i)
    , .dispatch_v_i(dispatch_v_i), .dispatch_poison_i(dispatch_poison_i)
    , .dispatch_instr_i(dispatch_instr_i)
    , .dispatch_rs1_i(dispatch_rs1_i), .dispatch_rs2_i(dispatch_rs2_i)
    , .fwd_v_i(fwd_v), .fwd_addr_i(fwd_addr), .fwd_data_i(fwd_data)
    , .res_instr_o(res_instr), .res_rs1_o(res_rs1), .res_rs2_o(res_rs2)
    , .res_int_v_o(res_int_v), .res_mul_v_o(res_mul_v)
    , .stage0_w_v_o(stage0_w_v), .stage0_rd_o(stage0_rd)
  );

  calc_pipe_int u_pipe_int
  (
      .res_instr_i(res_instr), .res_rs1_i(res_rs1), .res_rs2_i(res_rs2)
    , .res_int_v_i(res_int_v)
    , .int_data_o(int_data), .int_v_o(int_v)
  );

  calc_pipe_mul u_pipe_mul
  (
      .clk_i(clk_i), .arst_n_i(arst_n_i)
    , .res_rs1_i(res_rs1), .res_rs2_i(res_rs2), .res_mul_v_i(res_mul_v)
    , .mul_data_o(mul_data), .mul_v_o(mul_v)
  );

  calc_completion u_completion
  (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .flush_i(flush_i)
    , .stage0_w_v_i(stage0_w_v), .stage0_rd_i(stage0_rd)
    , .int_data_i(int_data), .int_v_i(int_v)
    , .mul_data_i(mul_data), .mul_v_i(mul_v)
    , .fwd_v_o(fwd_v), .fwd_addr_o(fwd_addr), .fwd_data_o(fwd_data)
    , .iwb_v_o(iwb_v_o), .iwb_addr_o(iwb_addr_o), .iwb_data_o(iwb_data_o)
  );

endmodule

//--- bench/calc_top_properties.sv
// ####################
// Bound checks on the writeback port
// ####################

`timescale 1ns/100ps

module calc_top_properties
(
    input  logic                                clk_i
  , input  logic                                arst_n_i
  , input  logic                                iwb_v_o
  , input  logic [calc_isa_pkg::REG_ADDR_W-1:0] iwb_addr_o
);

  // x0 is never written
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    iwb_v_o |-> (iwb_addr_o != '0))
    else $error("writeback valid with destination x0");

  a_valid_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(iwb_v_o))
    else $error("writeback valid is unknown");

  a_reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> !iwb_v_o)
    else $error("writeback valid high during reset");

endmodule

bind calc_top calc_top_properties u_properties
(
    .clk_i(clk_i), .arst_n_i(arst_n_i)
  , .iwb_v_o(iwb_v_o), .iwb_addr_o(iwb_addr_o)
);

//--- bench/calc_top_tb.sv
// ####################
// Execute stage testbench
// LFSR operands, reference model, directed tests
// ####################

`timescale 1ns/100ps

module calc_top_tb;

  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;

  localparam int LATENCY    = 3;
  localparam int WAIT_LIMIT = 50;

  typedef struct packed {
    logic [4:0]  addr;
    logic [31:0] data;
    logic [31:0] due;
  } wb_t;

  logic        clk_i;
  logic        arst_n_i;
  logic        dispatch_v_i;
  logic        dispatch_poison_i;
  instr_u      dispatch_instr_i;
  logic [31:0] dispatch_rs1_i;
  logic [31:0] dispatch_rs2_i;
  logic        flush_i;
  logic        iwb_v_o;
  logic [4:0]  iwb_addr_o;
  logic [31:0] iwb_data_o;

  int          errors = 0;
  int          checks = 0;
  int          cyc = 0;
  logic [31:0] lfsr = 32'h1b7a;
  logic [31:0] arch_rf [32];
  wb_t         exp_q [$];

  calc_top u_calc_top
  (
      .clk_i(clk_i), .arst_n_i(arst_n_i)
    , .dispatch_v_i(dispatch_v_i), .dispatch_poison_i(dispatch_poison_i)
    , .dispatch_instr_i(dispatch_instr_i)
    , .dispatch_rs1_i(dispatch_rs1_i), .dispatch_rs2_i(dispatch_rs2_i)
    , .flush_i(flush_i)
    , .iwb_v_o(iwb_v_o), .iwb_addr_o(iwb_addr_o), .iwb_data_o(iwb_data_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cyc <= cyc + 1;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        out;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      out  = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (out ? 32'h80200003 : 32'h0);
      val  = {val[30:0], out};
    end
    return val;
  endfunction

  // Result in the low bits, write flag on top
  function automatic logic [32:0] exec_model
  (
      input logic [31:0] w
    , input logic [31:0] a
    , input logic [31:0] b_reg
  );
    logic        known;
    logic [31:0] b;
    logic [31:0] r;
    known = 1'b0;
    r     = '0;
    b     = (w[6:0] == OPC_OP) ? b_reg : {{20{w[31]}}, w[31:20]};
    if (w[6:0] == OPC_OP && w[31:25] == FUNCT7_MULDIV && w[14:12] == F3_ADD)
    begin
      known = 1'b1;
      r     = a * b_reg;
    end
    else if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM)
    begin
      known = (w[6:0] == OPC_OP_IMM) || (w[31:25] == 7'h0)
              || (w[31:25] == FUNCT7_ALT && w[14:12] == F3_ADD);
      case (w[14:12])
        F3_ADD:  r = (w[6:0] == OPC_OP && w[31:25] == FUNCT7_ALT) ? a - b : a + b;
        F3_SLL:  r = a << b[4:0];
        F3_SLT:  r = {31'b0, $signed(a) < $signed(b)};
        F3_XOR:  r = a ^ b;
        F3_SRL:  r = a >> b[4:0];
        F3_OR:   r = a | b;
        F3_AND:  r = a & b;
        default: known = 1'b0;
      endcase
    end
    return {known && (w[11:7] != 5'd0), r};
  endfunction

  function automatic logic [31:0] r_op
  (
      input logic [6:0] f7
    , input logic [2:0] f3
    , input logic [4:0] rd
    , input logic [4:0] rs1
    , input logic [4:0] rs2
  );
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_op
  (
      input logic [11:0] imm
    , input logic [2:0]  f3
    , input logic [4:0]  rd
    , input logic [4:0]  rs1
  );
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic next_edge();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle(input int n);
    dispatch_v_i = 1'b0;
    repeat (n) next_edge();
  endtask

  // Drives one instruction and records the writeback it should make
  task automatic issue_op
  (
      input logic [31:0] w
    , input bit          bad1
    , input bit          bad2
    , input bit          poison
    , input bit          flush
    , input bit          cancelled
  );
    logic [31:0] a;
    logic [31:0] b;
    logic [32:0] m;
    wb_t         e;
    a = arch_rf[w[19:15]];
    b = arch_rf[w[24:20]];
    m = exec_model(w, a, b);
    dispatch_v_i      = 1'b1;
    dispatch_instr_i  = w;
    dispatch_rs1_i    = bad1 ? ~a : a;
    dispatch_rs2_i    = bad2 ? ~b : b;
    dispatch_poison_i = poison;
    flush_i           = flush;
    if (m[32] && !poison && !cancelled)
    begin
      arch_rf[w[11:7]] = m[31:0];
      e.addr = w[11:7];
      e.data = m[31:0];
      e.due  = cyc + 1 + LATENCY;
      exp_q.push_back(e);
    end
    next_edge();
    dispatch_v_i      = 1'b0;
    dispatch_poison_i = 1'b0;
    flush_i           = 1'b0;
  endtask

  always @(negedge clk_i)
  begin
    wb_t e;
    if (arst_n_i && exp_q.size() > 0 && exp_q[0].due == cyc)
    begin
      checks++;
      assert (iwb_v_o === 1'b1)
      else
      begin
        errors++;
        $display("%0t expected writeback to x%0d did not appear", $time, exp_q[0].addr);
        void'(exp_q.pop_front());
      end
    end
    if (arst_n_i && iwb_v_o === 1'b1)
    begin
      checks++;
      assert (exp_q.size() > 0)
      else
      begin
        errors++;
        $display("%0t writeback to x%0d that no instruction should make", $time, iwb_addr_o);
      end
      if (exp_q.size() > 0)
      begin
        e = exp_q.pop_front();
        check_val("iwb_addr_o", 32'(iwb_addr_o), 32'(e.addr));
        check_val("iwb_data_o", iwb_data_o, e.data);
        check_val("writeback cycle", cyc, e.due);
      end
    end
  end

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < WAIT_LIMIT)
    begin
      next_edge();
      n++;
    end
    if (exp_q.size() > 0)
    begin
      errors++;
      $display("%0t timeout while waiting for pending writebacks", $time);
      exp_q.delete();
    end
    // Room for a stray writeback to show up
    idle(LATENCY + 2);
  endtask

  task automatic test_reset();
    repeat (5)
    begin
      @(negedge clk_i);
      check_val("iwb_v_o", 32'(iwb_v_o), 32'h0);
    end
    @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    repeat (3)
    begin
      @(negedge clk_i);
      check_val("iwb_v_o", 32'(iwb_v_o), 32'h0);
    end
    next_edge();
  endtask

  task automatic test_alu_ops();
    logic [2:0]  f3s [7];
    logic [11:0] imm;
    f3s = '{F3_ADD, F3_SLL, F3_SLT, F3_XOR, F3_SRL, F3_OR, F3_AND};
    for (int i = 0; i < 7; i++)
    begin
      arch_rf[1] = rand_bits(32);
      arch_rf[2] = rand_bits(32);
      imm        = 12'(rand_bits(12));
      issue_op(r_op(7'h0, f3s[i], 5'(10 + i), 5'd1, 5'd2), 0, 0, 0, 0, 0);
      issue_op(i_op(imm, f3s[i], 5'(20 + i), 5'd1), 0, 0, 0, 0, 0);
    end
    issue_op(r_op(FUNCT7_ALT, F3_ADD, 5'd17, 5'd1, 5'd2), 0, 0, 0, 0, 0);
    drain();
  endtask

  // Consumer sees corrupted register values at distance d
  task automatic test_forwarding();
    for (int d = 1; d <= 4; d++)
    begin
      arch_rf[3] = rand_bits(32);
      issue_op(r_op(7'h0, F3_ADD, 5'd6, 5'd3, 5'd4), 0, 0, 0, 0, 0);
      for (int k = 0; k < d - 1; k++)
        issue_op(i_op(12'(rand_bits(12)), F3_XOR, 5'(21 + k), 5'd5), 0, 0, 0, 0, 0);
      issue_op(r_op(7'h0, F3_ADD, 5'd7, 5'd6, 5'd6), 1, 1, 0, 0, 0);
      drain();
    end
  endtask

  task automatic test_mul();
    arch_rf[3] = rand_bits(32);
    arch_rf[4] = rand_bits(32);
    issue_op(r_op(FUNCT7_MULDIV, F3_ADD, 5'd8, 5'd3, 5'd4), 0, 0, 0, 0, 0);
    idle(2);
    issue_op(r_op(7'h0, F3_ADD, 5'd9, 5'd8, 5'd3), 1, 0, 0, 0, 0);
    issue_op(r_op(FUNCT7_MULDIV, F3_ADD, 5'd10, 5'd1, 5'd2), 0, 0, 0, 0, 0);
    issue_op(r_op(FUNCT7_MULDIV, F3_ADD, 5'd11, 5'd2, 5'd4), 0, 0, 0, 0, 0);
    drain();
  endtask

  task automatic test_flush();
    issue_op(i_op(12'(rand_bits(12)), F3_ADD, 5'd12, 5'd0), 0, 0, 0, 0, 0);
    issue_op(i_op(12'(rand_bits(12)), F3_ADD, 5'd13, 5'd0), 0, 0, 0, 0, 1);
    issue_op(i_op(12'(rand_bits(12)), F3_ADD, 5'd14, 5'd0), 0, 0, 0, 0, 1);
    issue_op(i_op(12'(rand_bits(12)), F3_ADD, 5'd15, 5'd0), 0, 0, 0, 1, 1);
    drain();
  endtask

  task automatic test_no_write();
    issue_op(r_op(7'h0, F3_ADD, 5'd16, 5'd1, 5'd2), 0, 0, 1, 0, 0);
    issue_op(r_op(7'h0, F3_ADD, 5'd0, 5'd1, 5'd2), 0, 0, 0, 0, 0);
    issue_op({20'(rand_bits(20)), 5'd18, 7'b0110111}, 0, 0, 0, 0, 0);
    drain();
  endtask

  initial
  begin
    arst_n_i          = 1'b0;
    dispatch_v_i      = 1'b0;
    dispatch_poison_i = 1'b0;
    dispatch_instr_i  = '0;
    dispatch_rs1_i    = '0;
    dispatch_rs2_i    = '0;
    flush_i           = 1'b0;
    arch_rf[0]        = '0;
    for (int i = 1; i < 32; i++)
      arch_rf[i] = rand_bits(32);
    test_reset();
    test_alu_ops();
    test_forwarding();
    test_mul();
    test_flush();
    test_no_write();
    $display("errors %0d, checks %0d", errors, checks);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- calc.f
logic/calc_isa_pkg.sv
logic/calc_pipe_pkg.sv
logic/calc_issue.sv
logic/calc_pipe_int.sv
logic/calc_pipe_mul.sv
logic/calc_completion.sv
logic/calc_top.sv
bench/calc_top_properties.sv
bench/calc_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= calc_top_tb
FLIST     ?= calc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
